/* verilog.f */
verilog/calc_ctrl_pkg.sv
verilog/calc_data_pkg.sv
verilog/add_sub_unit.sv
verilog/shift_add_multiplier.sv
verilog/keypad_calc_ctrl.sv
verilog/keypad_calc_top.sv
dv/clk_rst_gen.sv
dv/calc_checker.sv
dv/tb_keypad_calc.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_keypad_calc
FILELIST  := verilog.f
BUILD_DIR := obj_dir
PASS_MSG  := Everything OK

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_keypad_calc.sv */
// Keypad calculator testbench
`timescale 1ns/1ps

module tb_keypad_calc;

    localparam int MULT_STEP_BITS = 2;
    localparam int N_EXPRESSIONS  = 46;
    localparam int WATCHDOG_NS    = N_EXPRESSIONS * (5 * 12 + 30) * 100 * 2;

    logic                            clk;
    logic                            nRST;
    logic [calc_ctrl_pkg::KEY_W-1:0] keypad_input;
    logic                            read_input;
    calc_ctrl_pkg::op_code_t         operator_input;
    logic                            equal_input;
    calc_data_pkg::word_t            display_output;
    logic                            complete;
    logic                            busy;
    int                              checks_passed;
    int                              checks_failed;
    int                              results_seen;
    int                              n_equations;

    clk_rst_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) clk_gen_i (
        .clk  (clk),
        .nRST (nRST)
    );

    keypad_calc_top #(
        .MULT_STEP_BITS (MULT_STEP_BITS)
    ) dut_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .display_output (display_output),
        .complete       (complete),
        .busy           (busy)
    );

    calc_checker check_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .display_output (display_output),
        .complete       (complete),
        .busy           (busy),
        .checks_passed  (checks_passed),
        .checks_failed  (checks_failed),
        .results_seen   (results_seen)
    );

    // All tasks start and end 1 ns after a rising edge
    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic press_digit(input logic [3:0] digit);
        keypad_input = digit;
        read_input   = 1'b1;
        @(posedge clk);
        #1;
        read_input = 1'b0;
        wait_idle();
    endtask

    // Second strobe set lands while the DUT is scaling
    task automatic press_digit_with_noise(input logic [3:0] digit);
        keypad_input = digit;
        read_input   = 1'b1;
        @(posedge clk);
        #1;
        keypad_input   = 4'd9;
        operator_input = calc_ctrl_pkg::OP_MUL;
        equal_input    = 1'b1;
        @(posedge clk);
        #1;
        read_input     = 1'b0;
        operator_input = calc_ctrl_pkg::OP_NONE;
        equal_input    = 1'b0;
        wait_idle();
    endtask

    task automatic press_operator(input calc_ctrl_pkg::op_code_t op);
        operator_input = op;
        @(posedge clk);
        #1;
        operator_input = calc_ctrl_pkg::OP_NONE;
    endtask

    task automatic press_equal();
        equal_input = 1'b1;
        @(posedge clk);
        #1;
        equal_input = 1'b0;
        while (!complete) begin
            @(posedge clk);
            #1;
        end
        wait_idle();
        n_equations++;
    endtask

    task automatic enter_operand(input int unsigned value);
        int unsigned digits[$];
        int unsigned rest;
        rest = value;
        do begin
            digits.push_front(rest % 10);
            rest = rest / 10;
        end while (rest != 0);
        foreach (digits[i]) press_digit(4'(digits[i]));
    endtask

    task automatic enter_random_operand();
        int unsigned n;
        n = $urandom_range(5, 1);
        repeat (n) press_digit(4'($urandom_range(9, 0)));
    endtask

    function automatic calc_ctrl_pkg::op_code_t pick_operator();
        int unsigned sel;
        sel = $urandom_range(2, 0);
        case (sel)
            0:       return calc_ctrl_pkg::OP_ADD;
            1:       return calc_ctrl_pkg::OP_SUB;
            default: return calc_ctrl_pkg::OP_MUL;
        endcase
    endfunction

    task automatic run_expression(
        input int unsigned             a,
        input calc_ctrl_pkg::op_code_t op,
        input int unsigned             b
    );
        enter_operand(a);
        press_operator(op);
        enter_operand(b);
        press_equal();
    endtask

    initial begin
        void'($urandom(47));
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = calc_ctrl_pkg::OP_NONE;
        equal_input    = 1'b0;
        n_equations    = 0;
        wait (nRST == 1'b1);
        repeat (2) @(posedge clk);
        #1;

        run_expression(1234, calc_ctrl_pkg::OP_ADD, 5678);
        run_expression(60000, calc_ctrl_pkg::OP_ADD, 9000);
        run_expression(25, calc_ctrl_pkg::OP_SUB, 300);
        run_expression(123, calc_ctrl_pkg::OP_MUL, 456);
        run_expression(999, calc_ctrl_pkg::OP_MUL, 999);

        press_digit_with_noise(4'd1);
        press_digit_with_noise(4'd2);
        press_operator(calc_ctrl_pkg::OP_ADD);
        press_digit_with_noise(4'd3);
        press_digit_with_noise(4'd4);
        press_equal();

        repeat (40) begin
            enter_random_operand();
            press_operator(pick_operator());
            enter_random_operand();
            press_equal();
        end

        repeat (3) @(posedge clk);
        $display("summary: %0d checks passed, %0d failed, %0d of %0d results seen",
                 checks_passed, checks_failed, results_seen, n_equations);
        if (results_seen != n_equations) begin
            $display("Error: %0d expressions were entered but %0d results were checked",
                     n_equations, results_seen);
        end
        if (checks_failed == 0 && results_seen == n_equations) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Error: run did not finish within %0d ns, DUT stuck busy or silent",
                 WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

/* dv/calc_checker.sv */
// Keypad calculator result checker
`timescale 1ns/1ps

module calc_checker (
    input  logic                            clk,
    input  logic                            nRST,
    input  logic [calc_ctrl_pkg::KEY_W-1:0] keypad_input,
    input  logic                            read_input,
    input  calc_ctrl_pkg::op_code_t         operator_input,
    input  logic                            equal_input,
    input  calc_data_pkg::word_t            display_output,
    input  logic                            complete,
    input  logic                            busy,
    output int                              checks_passed,
    output int                              checks_failed,
    output int                              results_seen
);

    calc_data_pkg::word_t    op1;
    calc_data_pkg::word_t    op2;
    calc_ctrl_pkg::op_code_t op_q;
    logic                    in_op2;
    logic                    result_due;
    logic                    reset_checked;
    logic                    digit_taken;

    // Reference arithmetic, unsigned and modulo 2^16
    function automatic calc_data_pkg::word_t expected_result(
        input calc_data_pkg::word_t    a,
        input calc_data_pkg::word_t    b,
        input calc_ctrl_pkg::op_code_t op
    );
        logic [31:0] product;
        case (op)
            calc_ctrl_pkg::OP_SUB: return a - b;
            calc_ctrl_pkg::OP_MUL: begin
                product = 32'(a) * 32'(b);
                return product[15:0];
            end
            default: return a + b;
        endcase
    endfunction

    // Operand times ten plus digit
    function automatic calc_data_pkg::word_t fold_digit(
        input calc_data_pkg::word_t            operand,
        input logic [calc_ctrl_pkg::KEY_W-1:0] digit
    );
        logic [31:0] wide;
        wide = 32'(operand) * 32'd10 + 32'(digit);
        return wide[15:0];
    endfunction

    function automatic string op_symbol(input calc_ctrl_pkg::op_code_t op);
        case (op)
            calc_ctrl_pkg::OP_SUB: return "-";
            calc_ctrl_pkg::OP_MUL: return "*";
            default:               return "+";
        endcase
    endfunction

    task automatic report_mismatch(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        $display("CHECK FAILED at %0d ns: %s expected %0d, got %0d",
                 $time, name, expected, actual);
        checks_failed++;
    endtask

    task automatic check_reset_values();
        int fails_before;
        fails_before = checks_failed;
        if (complete !== 1'b0) report_mismatch("complete", 32'd0, 32'(complete));
        if (busy !== 1'b0) report_mismatch("busy", 32'd0, 32'(busy));
        if (display_output !== '0) begin
            report_mismatch("display_output", 32'd0, 32'(display_output));
        end
        if (checks_failed == fails_before) begin
            checks_passed++;
            $display("test reset: outputs idle, ok");
        end else begin
            $display("test reset: outputs not idle, FAILED");
        end
    endtask

    task automatic compare_result();
        calc_data_pkg::word_t expected;
        if (!result_due) begin
            $display("Error at %0d ns: complete pulsed with no accepted equal key", $time);
            checks_failed++;
        end else begin
            expected = expected_result(op1, op2, op_q);
            results_seen++;
            if (display_output === expected) begin
                checks_passed++;
                $display("test %0d: %0d %s %0d = %0d, ok", results_seen,
                         op1, op_symbol(op_q), op2, display_output);
            end else begin
                report_mismatch("display_output", 32'(expected), 32'(display_output));
                $display("test %0d: %0d %s %0d, FAILED", results_seen,
                         op1, op_symbol(op_q), op2);
            end
        end
        // Next expression starts from empty operands
        op1        = '0;
        op2        = '0;
        in_op2     = 1'b0;
        result_due = 1'b0;
    endtask

    // Only strobes seen while the DUT is idle count
    task automatic track_inputs();
        if (read_input) begin
            if (in_op2) begin
                op2 = fold_digit(op2, keypad_input);
            end else begin
                op1 = fold_digit(op1, keypad_input);
            end
        end else if (!in_op2 && operator_input != calc_ctrl_pkg::OP_NONE) begin
            op_q   = operator_input;
            in_op2 = 1'b1;
        end else if (in_op2 && equal_input) begin
            result_due = 1'b1;
        end
    endtask

    initial begin
        checks_passed = 0;
        checks_failed = 0;
        results_seen  = 0;
        op1           = '0;
        op2           = '0;
        op_q          = calc_ctrl_pkg::OP_NONE;
        in_op2        = 1'b0;
        result_due    = 1'b0;
        reset_checked = 1'b0;
        digit_taken   = 1'b0;
    end

    always @(posedge clk) begin
        if (nRST) begin
            if (!reset_checked) begin
                check_reset_values();
                reset_checked = 1'b1;
            end
            // Busy is up in the cycle after a digit is taken
            if (digit_taken && busy !== 1'b1) begin
                report_mismatch("busy", 32'd1, 32'(busy));
            end
            digit_taken = !busy && read_input;
            if (complete) begin
                compare_result();
            end
            if (!busy) begin
                track_inputs();
            end
        end
    end

endmodule

/* dv/clk_rst_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Release just after an edge, like the other stimulus
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nRST = 1'b1;
    end

endmodule

/* verilog/keypad_calc_top.sv */
// Keypad calculator top level
`timescale 1ns/1ps

module keypad_calc_top #(
    parameter int MULT_STEP_BITS = 2
) (
    input  logic                            clk,
    input  logic                            nRST,
    input  logic [calc_ctrl_pkg::KEY_W-1:0] keypad_input,
    input  logic                            read_input,
    input  calc_ctrl_pkg::op_code_t         operator_input,
    input  logic                            equal_input,
    output calc_data_pkg::word_t            display_output,
    output logic                            complete,
    output logic                            busy
);

    calc_data_pkg::arith_req_t alu_req;
    calc_data_pkg::arith_req_t mult_req;
    calc_data_pkg::word_t      alu_result;
    calc_data_pkg::word_t      mult_result;
    logic                      alu_start;
    logic                      alu_finish;
    logic                      mult_start;
    logic                      mult_finish;

    keypad_calc_ctrl ctrl_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .alu_req        (alu_req),
        .alu_start      (alu_start),
        .alu_result     (alu_result),
        .alu_finish     (alu_finish),
        .mult_req       (mult_req),
        .mult_start     (mult_start),
        .mult_result    (mult_result),
        .mult_finish    (mult_finish),
        .display_output (display_output),
        .complete       (complete),
        .busy           (busy)
    );

    add_sub_unit alu_i (
        .clk    (clk),
        .nRST   (nRST),
        .req    (alu_req),
        .start  (alu_start),
        .result (alu_result),
        .finish (alu_finish)
    );

    shift_add_multiplier #(
        .MULT_STEP_BITS (MULT_STEP_BITS)
    ) mult_i (
        .clk    (clk),
        .nRST   (nRST),
        .req    (mult_req),
        .start  (mult_start),
        .result (mult_result),
        .finish (mult_finish)
    );

endmodule

/* verilog/keypad_calc_ctrl.sv */
// Keypad calculator controller
`timescale 1ns/1ps

module keypad_calc_ctrl (
    input  logic                              clk,
    input  logic                              nRST,
    input  logic [calc_ctrl_pkg::KEY_W-1:0]   keypad_input,
    input  logic                              read_input,
    input  calc_ctrl_pkg::op_code_t           operator_input,
    input  logic                              equal_input,
    output calc_data_pkg::arith_req_t         alu_req,
    output logic                              alu_start,
    input  calc_data_pkg::word_t              alu_result,
    input  logic                              alu_finish,
    output calc_data_pkg::arith_req_t         mult_req,
    output logic                              mult_start,
    input  calc_data_pkg::word_t              mult_result,
    input  logic                              mult_finish,
    output calc_data_pkg::word_t              display_output,
    output logic                              complete,
    output logic                              busy
);

    localparam calc_data_pkg::word_t TEN = calc_data_pkg::word_t'(10);

    calc_ctrl_pkg::ctrl_state_t            state;
    calc_ctrl_pkg::ctrl_state_t            state_nxt;
    calc_data_pkg::word_t                  operand1;
    calc_data_pkg::word_t                  operand2;
    calc_data_pkg::word_t                  entry_operand;
    calc_data_pkg::word_t                  digit_word;
    calc_data_pkg::word_t                  result_sel;
    logic [calc_ctrl_pkg::KEY_W-1:0]       digit_q;
    calc_ctrl_pkg::op_code_t               op_q;
    logic                                  in_entry;
    logic                                  take_digit;
    logic                                  is_mul;
    logic                                  result_ready;

    assign in_entry   = (state == calc_ctrl_pkg::OP1_ENTRY) ||
                        (state == calc_ctrl_pkg::OP2_ENTRY);
    assign take_digit = in_entry && read_input;
    assign busy       = !in_entry;

    assign entry_operand = (state == calc_ctrl_pkg::OP2_ENTRY) ? operand2 : operand1;
    assign digit_word    = calc_data_pkg::word_t'(digit_q);

    // Only the selected unit's finish counts
    assign is_mul       = (op_q == calc_ctrl_pkg::OP_MUL);
    assign result_ready = is_mul ? mult_finish : alu_finish;
    assign result_sel   = is_mul ? mult_result : alu_result;

    always_comb begin
        state_nxt = state;
        case (state)
            calc_ctrl_pkg::OP1_ENTRY: begin
                if (read_input) begin
                    state_nxt = calc_ctrl_pkg::OP1_SCALE;
                end else if (operator_input != calc_ctrl_pkg::OP_NONE) begin
                    state_nxt = calc_ctrl_pkg::OP2_ENTRY;
                end
            end
            calc_ctrl_pkg::OP1_SCALE: begin
                if (mult_finish) begin
                    state_nxt = calc_ctrl_pkg::OP1_FOLD;
                end
            end
            calc_ctrl_pkg::OP1_FOLD:  state_nxt = calc_ctrl_pkg::OP1_ENTRY;
            calc_ctrl_pkg::OP2_ENTRY: begin
                if (read_input) begin
                    state_nxt = calc_ctrl_pkg::OP2_SCALE;
                end else if (equal_input) begin
                    state_nxt = calc_ctrl_pkg::DISPATCH;
                end
            end
            calc_ctrl_pkg::OP2_SCALE: begin
                if (mult_finish) begin
                    state_nxt = calc_ctrl_pkg::OP2_FOLD;
                end
            end
            calc_ctrl_pkg::OP2_FOLD:  state_nxt = calc_ctrl_pkg::OP2_ENTRY;
            calc_ctrl_pkg::DISPATCH:  state_nxt = calc_ctrl_pkg::WAIT_RESULT;
            calc_ctrl_pkg::WAIT_RESULT: begin
                if (result_ready) begin
                    state_nxt = calc_ctrl_pkg::SHOW;
                end
            end
            calc_ctrl_pkg::SHOW:      state_nxt = calc_ctrl_pkg::OP1_ENTRY;
            default:                  state_nxt = calc_ctrl_pkg::OP1_ENTRY;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= calc_ctrl_pkg::OP1_ENTRY;
            operand1       <= '0;
            operand2       <= '0;
            alu_start      <= 1'b0;
            mult_start     <= 1'b0;
            display_output <= '0;
            complete       <= 1'b0;
        end else begin
            state      <= state_nxt;
            alu_start  <= 1'b0;
            mult_start <= 1'b0;
            complete   <= 1'b0;
            case (state)
                calc_ctrl_pkg::OP1_ENTRY,
                calc_ctrl_pkg::OP2_ENTRY: mult_start <= read_input;
                calc_ctrl_pkg::OP1_SCALE: begin
                    if (mult_finish) begin
                        operand1 <= mult_result;
                    end
                end
                calc_ctrl_pkg::OP1_FOLD:  operand1 <= operand1 + digit_word;
                calc_ctrl_pkg::OP2_SCALE: begin
                    if (mult_finish) begin
                        operand2 <= mult_result;
                    end
                end
                calc_ctrl_pkg::OP2_FOLD:  operand2 <= operand2 + digit_word;
                calc_ctrl_pkg::DISPATCH: begin
                    alu_start  <= !is_mul;
                    mult_start <= is_mul;
                end
                // Display and complete line up with the SHOW cycle
                calc_ctrl_pkg::WAIT_RESULT: begin
                    if (result_ready) begin
                        display_output <= result_sel;
                        complete       <= 1'b1;
                    end
                end
                calc_ctrl_pkg::SHOW: begin
                    operand1 <= '0;
                    operand2 <= '0;
                end
                default: ;
            endcase
        end
    end

    // Latched digit, operator and unit requests
    always_ff @(posedge clk) begin
        if (take_digit) begin
            digit_q  <= keypad_input;
            mult_req <= '{a: entry_operand, b: TEN, sub: 1'b0};
        end else if (state == calc_ctrl_pkg::OP1_ENTRY &&
                     operator_input != calc_ctrl_pkg::OP_NONE) begin
            op_q <= operator_input;
        end
        if (state == calc_ctrl_pkg::DISPATCH) begin
            alu_req <= '{a: operand1, b: operand2, sub: (op_q == calc_ctrl_pkg::OP_SUB)};
            if (is_mul) begin
                mult_req <= '{a: operand1, b: operand2, sub: 1'b0};
            end
        end
    end

    // A start never meets the other start or a finish still in flight
    a_one_start: assert property (
        @(posedge clk) disable iff (!nRST)
        (alu_start || mult_start) |->
            !(alu_start && mult_start) && !alu_finish && !mult_finish
    ) else $error("keypad_calc_ctrl: start overlaps another start or a finish");

endmodule

/* verilog/shift_add_multiplier.sv */
// Sequential shift-and-add multiplier
`timescale 1ns/1ps

module shift_add_multiplier #(
    parameter int MULT_STEP_BITS = 2
) (
    input  logic                      clk,
    input  logic                      nRST,
    input  calc_data_pkg::arith_req_t req,
    input  logic                      start,
    output calc_data_pkg::word_t      result,
    output logic                      finish
);

    localparam int STEPS = calc_data_pkg::WORD_W / MULT_STEP_BITS;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic [CNT_W-1:0]     count;
    logic                 running;
    logic                 load;
    calc_data_pkg::word_t mcand;
    calc_data_pkg::word_t mplier;
    calc_data_pkg::word_t acc;
    calc_data_pkg::word_t step_sum;

    assign running = (count != '0);
    assign load    = start && !running;

    // Partial products for the low MULT_STEP_BITS multiplier bits
    always_comb begin
        step_sum = acc;
        for (int i = 0; i < MULT_STEP_BITS; i++) begin
            if (mplier[i]) begin
                step_sum = step_sum + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (load) begin
                count <= CNT_W'(STEPS);
            end else if (running) begin
                count <= count - 1'b1;
                // Last step lands together with the finish pulse
                finish <= (count == CNT_W'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= req.a;
            mplier <= req.b;
            acc    <= '0;
        end else if (running) begin
            acc    <= step_sum;
            mcand  <= mcand << MULT_STEP_BITS;
            mplier <= mplier >> MULT_STEP_BITS;
        end
    end

    // Product held until the next load, truncated to the word width
    assign result = acc;

    if (calc_data_pkg::WORD_W % MULT_STEP_BITS != 0) begin : g_step_check
        $error("shift_add_multiplier: MULT_STEP_BITS must divide the word width");
    end

    a_no_start_while_running: assert property (
        @(posedge clk) disable iff (!nRST)
        start |-> !running
    ) else $error("shift_add_multiplier: start while running");

endmodule

/* verilog/add_sub_unit.sv */
// Registered add/subtract unit
`timescale 1ns/1ps

module add_sub_unit (
    input  logic                      clk,
    input  logic                      nRST,
    input  calc_data_pkg::arith_req_t req,
    input  logic                      start,
    output calc_data_pkg::word_t      result,
    output logic                      finish
);

    // Finish follows start by exactly one cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (req.sub) begin
                result <= req.a - req.b;
            end else begin
                result <= req.a + req.b;
            end
        end
    end

    // Controller must not restart the unit in the finish cycle
    a_no_double_finish: assert property (
        @(posedge clk) disable iff (!nRST)
        finish |=> !finish
    ) else $error("add_sub_unit: finish high on two consecutive cycles");

endmodule

/* verilog/calc_data_pkg.sv */
// Calculator datapath types
package calc_data_pkg;

    // Operand and result width
    localparam int WORD_W = 16;

    // Unsigned word, arithmetic wraps modulo 2^WORD_W
    typedef logic [WORD_W-1:0] word_t;

    // Request to an arithmetic unit
    // Multiplier ignores sub
    typedef struct packed {
        word_t a;
        word_t b;
        logic  sub;
    } arith_req_t;

endpackage

/* verilog/calc_ctrl_pkg.sv */
// Keypad calculator control definitions
package calc_ctrl_pkg;

    // Width of one keypad digit
    localparam int KEY_W = 4;

    // Operator codes as the keypad delivers them
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b100
    } op_code_t;

    // Controller states
    typedef enum logic [3:0] {
        OP1_ENTRY,
        OP1_SCALE,
        OP1_FOLD,
        OP2_ENTRY,
        OP2_SCALE,
        OP2_FOLD,
        DISPATCH,
        WAIT_RESULT,
        SHOW
    } ctrl_state_t;

endpackage
